/* all.f */
+incdir+include
hdl/ciIsaPkg.sv
hdl/timingPkg.sv
hdl/ciDispatch.sv
hdl/profileCounters.sv
hdl/microDelay.sv
hdl/ciSubsystem.sv
test/ciSubsystemTb.sv

/* hdl/ciDispatch.sv */
`timescale 1ns/1ps

module ciDispatch (
  input  logic                             ciStart,
  input  logic [ciIsaPkg::ciIdWidth-1:0]   ciN,
  output logic                             profileStart,
  output logic                             delayStart,
  input  logic                             profileDone,
  input  logic [ciIsaPkg::ciWordWidth-1:0] profileResult,
  input  logic                             delayDone,
  input  logic [ciIsaPkg::ciWordWidth-1:0] delayResult,
  output logic                             ciDone,
  output logic [ciIsaPkg::ciWordWidth-1:0] ciResult
);

  import ciIsaPkg::*;

  logic profileMatch;
  logic delayMatch;

  assign profileMatch = (ciN == profileOp);
  assign delayMatch   = (ciN == delayOp);

  // only the owning unit sees the strobe.
  assign profileStart = ciStart & profileMatch;
  assign delayStart   = ciStart & delayMatch;

  // idle units drive zero, so a plain OR merges the answers.
  assign ciDone   = profileDone | delayDone;
  assign ciResult = profileResult | delayResult;

endmodule

/* hdl/ciIsaPkg.sv */
package ciIsaPkg;

  // one processor word, used for both operands and the result.
  localparam int ciWordWidth = 32;

  // width of the custom instruction number.
  localparam int ciIdWidth = 8;

  // instruction numbers served by this subsystem.
  typedef enum logic [ciIdWidth-1:0] {
    delayOp   = 8'h06,  // blocking microsecond delay.
    profileOp = 8'h0C   // profiling counters.
  } ciOpcode;

  // number of profiling counters and the width of their select field.
  localparam int profileCounterCount = 4;
  localparam int profileSelectWidth  = 2;

  // counter select, taken from valueA of a profile instruction.
  typedef enum logic [profileSelectWidth-1:0] {
    cycleCount    = 2'd0,  // every clock.
    stallCount    = 2'd1,  // stall high.
    idleCount     = 2'd2,  // bus idle.
    memStallCount = 2'd3   // stall high while the bus is busy.
  } profileSelect;

  // control fields in valueB of a profile instruction.
  localparam int profileEnableLsb = 0;  // enable bits [3:0].
  localparam int profileClearLsb  = 8;  // clear bits [11:8].

endpackage

/* hdl/ciSubsystem.sv */
`timescale 1ns/1ps

module ciSubsystem #(
  parameter int unsigned systemClockInHz = timingPkg::defaultSystemClockHz
) (
  input  logic                             s_systemClock,
  input  logic                             s_pllLocked,
  input  logic                             ciStart,
  input  logic [ciIsaPkg::ciIdWidth-1:0]   ciN,
  input  logic [ciIsaPkg::ciWordWidth-1:0] ciDataA,
  input  logic [ciIsaPkg::ciWordWidth-1:0] ciDataB,
  input  logic                             stall,
  input  logic                             busIdle,
  output logic                             ciDone,
  output logic [ciIsaPkg::ciWordWidth-1:0] ciResult
);

  import ciIsaPkg::*;

  logic                   profileStart;
  logic                   profileDone;
  logic [ciWordWidth-1:0] profileResult;
  logic                   delayStart;
  logic                   delayDone;
  logic [ciWordWidth-1:0] delayResult;

  ciDispatch ciDispatch_inst (
    .ciStart      (ciStart),
    .ciN          (ciN),
    .profileStart (profileStart),
    .delayStart   (delayStart),
    .profileDone  (profileDone),
    .profileResult(profileResult),
    .delayDone    (delayDone),
    .delayResult  (delayResult),
    .ciDone       (ciDone),
    .ciResult     (ciResult)
  );

  profileCounters profileCounters_inst (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .start        (profileStart),
    .stall        (stall),
    .busIdle      (busIdle),
    .valueA       (ciDataA),
    .valueB       (ciDataB),
    .done         (profileDone),
    .result       (profileResult)
  );

  microDelay #(
    .systemClockInHz(systemClockInHz)
  ) microDelay_inst (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .start        (delayStart),
    .valueA       (ciDataA),
    .done         (delayDone),
    .result       (delayResult)
  );

endmodule

/* hdl/microDelay.sv */
`timescale 1ns/1ps

module microDelay #(
  parameter int unsigned systemClockInHz = timingPkg::defaultSystemClockHz
) (
  input  logic                             s_systemClock,
  input  logic                             s_pllLocked,
  input  logic                             start,
  input  logic [ciIsaPkg::ciWordWidth-1:0] valueA,
  output logic                             done,
  output logic [ciIsaPkg::ciWordWidth-1:0] result
);

  import ciIsaPkg::*;
  import timingPkg::*;

  localparam int unsigned ticksPerMicro = systemClockInHz / microsecondHz;
  localparam int prescaleWidth = (ticksPerMicro > 1) ? $clog2(ticksPerMicro) : 1;
  localparam logic [prescaleWidth-1:0] prescaleReload = prescaleWidth'(ticksPerMicro - 1);

  delayState                stateReg;
  delayState                stateNext;
  logic                     zeroPending;
  logic                     acceptStart;
  logic                     lastTick;
  logic [prescaleWidth-1:0] prescaleCount;
  logic [ciWordWidth-1:0]   usRemaining;

  // the processor is blocked while a delay runs, so later starts are dropped.
  assign acceptStart = start & (stateReg == idleState) & ~zeroPending;

  assign lastTick = (stateReg == countState) && (prescaleCount == '0) &&
                    (usRemaining == ciWordWidth'(1));

  always_comb begin
    stateNext = stateReg;
    case (stateReg)
      idleState: begin
        if (acceptStart && valueA != '0) begin
          stateNext = countState;
        end
      end
      countState: begin
        if (lastTick) begin
          stateNext = idleState;
        end
      end
      default: stateNext = idleState;
    endcase
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      stateReg    <= idleState;
      zeroPending <= 1'b0;
    end else begin
      stateReg    <= stateNext;
      zeroPending <= acceptStart && (valueA == '0);  // zero request answers next cycle.
    end
  end

  // prescaler restarts on every accepted start.
  always_ff @(posedge s_systemClock) begin
    if (acceptStart) begin
      prescaleCount <= prescaleReload;
      usRemaining   <= valueA;
    end else if (stateReg == countState) begin
      if (prescaleCount == '0) begin
        prescaleCount <= prescaleReload;
        usRemaining   <= usRemaining - 1'b1;  // one microsecond elapsed.
      end else begin
        prescaleCount <= prescaleCount - 1'b1;
      end
    end
  end

  assign done   = lastTick | zeroPending;
  assign result = '0;

endmodule

/* hdl/profileCounters.sv */
`timescale 1ns/1ps

module profileCounters (
  input  logic                             s_systemClock,
  input  logic                             s_pllLocked,
  input  logic                             start,
  input  logic                             stall,
  input  logic                             busIdle,
  input  logic [ciIsaPkg::ciWordWidth-1:0] valueA,
  input  logic [ciIsaPkg::ciWordWidth-1:0] valueB,
  output logic                             done,
  output logic [ciIsaPkg::ciWordWidth-1:0] result
);

  import ciIsaPkg::*;
  import timingPkg::*;

  logic [profileCountWidth-1:0]   counterValue [profileCounterCount];
  logic [profileCounterCount-1:0] enableReg;
  logic [profileCounterCount-1:0] nextEnable;
  logic [profileCounterCount-1:0] clearMask;
  logic [profileCounterCount-1:0] countEvent;
  profileSelect                   readSelect;

  // count conditions, one bit per counter.
  assign countEvent[cycleCount]    = 1'b1;
  assign countEvent[stallCount]    = stall;
  assign countEvent[idleCount]     = busIdle;
  assign countEvent[memStallCount] = stall & ~busIdle;

  // a start loads the enables and clears selected counters at the same edge.
  assign nextEnable = start ? valueB[profileEnableLsb +: profileCounterCount] : enableReg;
  assign clearMask  = start ? valueB[profileClearLsb +: profileCounterCount] : '0;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      enableReg <= '0;
      for (int i = 0; i < profileCounterCount; i++) begin
        counterValue[i] <= '0;
      end
    end else begin
      enableReg <= nextEnable;
      for (int i = 0; i < profileCounterCount; i++) begin
        if (clearMask[i]) begin
          counterValue[i] <= '0;  // clear wins over an increment.
        end else if (nextEnable[i] && countEvent[i]) begin
          counterValue[i] <= counterValue[i] + 1'b1;
        end
      end
    end
  end

  assign readSelect = profileSelect'(valueA[profileSelectWidth-1:0]);

  // answer in the start cycle with the value from before the edge.
  assign done   = start;
  assign result = start ? ciWordWidth'(counterValue[readSelect]) : '0;

endmodule

/* hdl/timingPkg.sv */
package timingPkg;

  // system clock of the reference board.
  localparam int unsigned defaultSystemClockHz = 74_250_000;

  // one microsecond expressed as a frequency.
  localparam int unsigned microsecondHz = 1_000_000;

  // width of each profiling counter.
  localparam int profileCountWidth = 32;

  // states of the microsecond delay unit.
  typedef enum logic {
    idleState  = 1'b0,  // waiting for a start.
    countState = 1'b1   // counting down microseconds.
  } delayState;

endpackage

/* runSim.sh */
#!/bin/sh
# Compile and run the custom-instruction testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f all.f \
  --top-module ciSubsystemTb -o ciSubsystemSim

status=0
./obj_dir/ciSubsystemSim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit "$status"
fi

echo "simulation finished without failures"

/* include/ciSubsystemModel.svh */
`ifndef CI_SUBSYSTEM_MODEL_SVH
`define CI_SUBSYSTEM_MODEL_SVH

// model of the four profiling counters and their enable bits.
logic [timingPkg::profileCountWidth-1:0] modelCount [ciIsaPkg::profileCounterCount];
logic [ciIsaPkg::profileCounterCount-1:0] modelEnable;

// cycles from the start cycle to the done pulse.
function automatic int unsigned expectedDelayCycles(input int unsigned micros,
                                                    input int unsigned clockHz);
  int unsigned ticks;
  ticks = clockHz / timingPkg::microsecondHz;
  return (micros == 0) ? 1 : micros * ticks;
endfunction

function automatic void modelReset();
  modelEnable = '0;
  for (int i = 0; i < ciIsaPkg::profileCounterCount; i++) begin
    modelCount[i] = '0;
  end
endfunction

// one rising edge; start is the profile start seen in the cycle before it.
function automatic void modelStep(input logic start, input logic [31:0] dataB,
                                  input logic stall, input logic busIdle);
  logic [ciIsaPkg::profileCounterCount-1:0] clear;
  logic [ciIsaPkg::profileCounterCount-1:0] event_;
  clear  = start ? dataB[11:8] : '0;
  event_ = {stall & ~busIdle, busIdle, stall, 1'b1};
  if (start) begin
    modelEnable = dataB[3:0];
  end
  for (int i = 0; i < ciIsaPkg::profileCounterCount; i++) begin
    if (clear[i]) begin
      modelCount[i] = '0;  // clear wins.
    end else if (modelEnable[i] && event_[i]) begin
      modelCount[i] = modelCount[i] + 1'b1;
    end
  end
endfunction

function automatic logic [31:0] modelRead(input logic [1:0] sel);
  return 32'(modelCount[sel]);
endfunction

`endif

/* test/ciSubsystemTb.sv */
`timescale 1ns/1ps

module ciSubsystemTb;

  import ciIsaPkg::*;

  localparam int unsigned tbClockHz      = 4_000_000;  // one microsecond is 4 cycles.
  localparam int unsigned randomSeed     = 32'h82f1_f252;
  localparam int          profileTimeout = 2;
  localparam int          delayMargin    = 4;
  localparam int          unownedWindow  = 16;

  logic                   s_systemClock;
  logic                   s_pllLocked;
  logic                   ciStart;
  logic [ciIdWidth-1:0]   ciN;
  logic [ciWordWidth-1:0] ciDataA;
  logic [ciWordWidth-1:0] ciDataB;
  logic                   stall = 1'b0;
  logic                   busIdle = 1'b0;
  logic                   ciDone;
  logic [ciWordWidth-1:0] ciResult;

  logic        levelsRandom;
  logic [3:0]  enableMask;
  int unsigned delayRemaining = 0;

  `include "ciSubsystemModel.svh"

  ciSubsystem #(
    .systemClockInHz(tbClockHz)
  ) ciSubsystem_inst (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .stall        (stall),
    .busIdle      (busIdle),
    .ciDone       (ciDone),
    .ciResult     (ciResult)
  );

  always #10 s_systemClock = ~s_systemClock;  // 20 ns period.

  task automatic failRun();
    $display("** FAIL **");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic reportFailure(input string what);
    $display("Failure at %0d ns: %s", $time, what);
    failRun();
  endtask

  task automatic checkValue(input string what, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
      failRun();
    end
  endtask

  // bus activity levels change at random on every edge once reset is over.
  always @(posedge s_systemClock) begin
    if (levelsRandom) begin
      stall   <= ($urandom % 2) == 1;
      busIdle <= ($urandom % 2) == 1;
    end
  end

  // counter model follows the same edges as the DUT.
  always @(posedge s_systemClock) begin
    if (!s_pllLocked) begin
      modelReset();
    end else begin
      modelStep(ciStart && (ciN == profileOp), ciDataB, stall, busIdle);
    end
  end

  // outputs are combinational, so they are compared at the falling edge.
  always @(negedge s_systemClock) begin
    logic                   expDone;
    logic [ciWordWidth-1:0] expResult;
    logic                   delayBusy;
    if (!s_pllLocked) begin
      delayRemaining = 0;
    end else begin
      expDone   = 1'b0;
      expResult = '0;
      delayBusy = (delayRemaining != 0);
      if (delayBusy) begin
        delayRemaining--;
        if (delayRemaining == 0) begin
          expDone = 1'b1;  // delay answers now, result stays zero.
        end
      end
      if (ciStart && (ciN == profileOp)) begin
        expDone   = 1'b1;
        expResult = modelRead(ciDataA[1:0]);
      end
      if (ciStart && (ciN == delayOp) && !delayBusy) begin
        delayRemaining = expectedDelayCycles(ciDataA, tbClockHz);
      end
      checkValue("ciDone", 32'(ciDone), 32'(expDone));
      checkValue("ciResult", ciResult, expResult);
    end
  end

  task automatic idleCycles(input int count);
    repeat (count) @(posedge s_systemClock);
  endtask

  // one strobe, then wait for the answer with a limit in cycles.
  task automatic runInstruction(input logic [7:0] number, input logic [31:0] dataA,
                                input logic [31:0] dataB, input int limit,
                                output logic answered, output logic [31:0] answer,
                                output int latency);
    int waited;
    answered = 1'b0;
    answer   = '0;
    latency  = 0;
    waited   = 0;
    @(posedge s_systemClock);
    ciStart <= 1'b1;
    ciN     <= number;
    ciDataA <= dataA;
    ciDataB <= dataB;
    while (!answered && waited <= limit) begin
      @(negedge s_systemClock);
      if (ciDone) begin
        answered = 1'b1;
        answer   = ciResult;
        latency  = waited;
      end
      @(posedge s_systemClock);
      ciStart <= 1'b0;
      waited++;
    end
  endtask

  task automatic readCounter(input logic [1:0] sel, output logic [31:0] value);
    logic answered;
    int   latency;
    runInstruction(profileOp, 32'(sel), 32'(enableMask), profileTimeout,
                   answered, value, latency);
    if (!answered) begin
      reportFailure($sformatf("read of profile counter %0d never answered", sel));
    end
    checkValue("profile read latency", 32'(latency), 32'd0);  // same cycle as start.
  endtask

  task automatic controlCounters(input logic [3:0] enables, input logic [3:0] clears);
    logic        answered;
    logic [31:0] value;
    int          latency;
    enableMask = enables;
    runInstruction(profileOp, 32'd0, {20'd0, clears, 4'd0, enables}, profileTimeout,
                   answered, value, latency);
    if (!answered) begin
      reportFailure("profile control instruction never answered");
    end
  endtask

  task automatic runDelay(input int unsigned micros);
    logic        answered;
    logic [31:0] value;
    int          latency;
    int          limit;
    limit = expectedDelayCycles(micros, tbClockHz) + delayMargin;
    runInstruction(delayOp, micros, 32'd0, limit, answered, value, latency);
    if (!answered) begin
      reportFailure($sformatf("delay of %0d us never answered", micros));
    end
    checkValue("delay result", value, 32'd0);
  endtask

  initial begin
    logic [31:0] value;
    logic [31:0] heldIdle;
    logic        answered;
    int          latency;
    void'($urandom(randomSeed));
    s_systemClock = 1'b0;
    s_pllLocked   = 1'b0;
    ciStart       = 1'b0;
    ciN           = '0;
    ciDataA       = '0;
    ciDataB       = '0;
    levelsRandom  = 1'b0;
    enableMask    = '0;
    modelReset();
    repeat (2) @(posedge s_systemClock);
    s_pllLocked  <= 1'b1;
    levelsRandom <= 1'b1;

    // counters start at zero.
    for (int sel = 0; sel < 4; sel++) begin
      readCounter(2'(sel), value);
      checkValue("counter after reset", value, 32'd0);
    end

    // free counting with random bus activity.
    controlCounters(4'hF, 4'h0);
    idleCycles($urandom_range(200, 50));
    for (int sel = 0; sel < 4; sel++) begin
      readCounter(2'(sel), value);
    end

    // clear cycle and stall counters, stop the idle counter.
    idleCycles($urandom_range(40, 10));
    controlCounters(4'b1011, 4'b0011);
    readCounter(cycleCount, value);
    checkValue("cycleCount one edge after clear", value, 32'd1);
    readCounter(idleCount, heldIdle);
    idleCycles($urandom_range(60, 20));
    readCounter(idleCount, value);
    checkValue("disabled idleCount", value, heldIdle);
    for (int sel = 0; sel < 4; sel++) begin
      readCounter(2'(sel), value);
    end

    // blocking delays with their exact latency checked at every falling edge.
    runDelay(0);
    repeat (8) begin
      runDelay($urandom_range(20, 0));
    end
    runDelay(20);

    // nobody owns this number.
    runInstruction(8'h55, 32'h0000_1234, 32'(enableMask), unownedWindow,
                   answered, value, latency);
    if (answered) begin
      reportFailure("unowned instruction number 0x55 got a done pulse");
    end
    readCounter(memStallCount, value);
    readCounter(cycleCount, value);

    idleCycles(4);
    $display("** PASS **");
    $finish;
  end

endmodule
